/* source/merge_pkg.sv */
`default_nettype none

package merge_pkg;

	// Word address and data widths
	localparam int unsigned addr_w = 8;
	localparam int unsigned data_w = 32;
	localparam int unsigned strb_w = data_w / 8;

	// Lookup table depth, one entry per request id
	localparam int unsigned num_outstanding = 16;
	localparam int unsigned id_w = $clog2(num_outstanding);
	localparam int unsigned tag_w = 4;

	typedef logic [id_w-1:0] req_id_t;

	// Tag is opaque to the stage
	typedef struct packed {
		req_id_t            req_id;
		logic [tag_w-1:0]   tag;
	} user_t;

	typedef struct packed {
		logic [addr_w-1:0]  addr;
		logic               write;
		logic [strb_w-1:0]  strb;
		logic [data_w-1:0]  data;
		user_t              user;
	} mem_req_t;

	typedef struct packed {
		logic               write;
		logic [data_w-1:0]  data;
		user_t              user;
	} mem_rsp_t;

	// Storage word, written per byte lane and read whole
	typedef union packed {
		logic [data_w-1:0]            word;
		logic [strb_w-1:0][7:0]       bytes;
	} mem_word_u;

	// Pending merged write, port 1 user kept for the fan-out
	typedef struct packed {
		logic   owed0;
		logic   owed1;
		user_t  user1;
	} lut_entry_t;

endpackage

`default_nettype wire

/* source/port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface port_if (
	input logic clk_i
);
	import merge_pkg::*;

	// Request channel
	mem_req_t req;
	logic q_valid;
	logic q_ready;

	// Response channel
	mem_rsp_t rsp;
	logic p_valid;
	logic p_ready;

	// Side that issues requests and takes responses
	modport requester (
		input  clk_i,
		output req, q_valid, p_ready,
		input  q_ready, rsp, p_valid
	);

	// Side that accepts requests and returns responses
	modport responder (
		input  clk_i,
		input  req, q_valid, p_ready,
		output q_ready, rsp, p_valid
	);

	// Observe only
	modport monitor (
		input clk_i, req, q_valid, q_ready, rsp, p_valid, p_ready
	);

endinterface

`default_nettype wire

/* source/merge_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module merge_decode (
	port_if.monitor                      port0_i,
	port_if.monitor                      port1_i,
	output logic                         merge_o,
	output logic [merge_pkg::strb_w-1:0] merged_strb_o,
	output logic [merge_pkg::data_w-1:0] merged_data_o
);
	import merge_pkg::*;

	logic both_valid;
	logic both_write;
	logic same_addr;

	// Both ports must present a request this cycle
	assign both_valid = port0_i.q_valid && port1_i.q_valid;

	// Reads never merge
	assign both_write = port0_i.req.write && port1_i.req.write;

	assign same_addr = (port0_i.req.addr == port1_i.req.addr);

	assign merge_o = both_valid && both_write && same_addr;

	// Combined write covers every lane either port touches
	assign merged_strb_o = port0_i.req.strb | port1_i.req.strb;

	// Lane select per byte
	// port 1 overrides port 0 wherever it strobes
	for (genvar i = 0; i < strb_w; i++) begin : gen_lane
		assign merged_data_o[i*8 +: 8] = port1_i.req.strb[i] ?
			port1_i.req.data[i*8 +: 8] : port0_i.req.data[i*8 +: 8];
	end

endmodule

`default_nettype wire

/* source/merge_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module merge_execute (
	input  logic                         clk_i,
	input  logic                         reset_i,
	port_if.responder                    core0_i,
	port_if.responder                    core1_i,
	port_if.requester                    mem0_o,
	port_if.requester                    mem1_o,
	input  logic                         merge_i,
	input  logic [merge_pkg::strb_w-1:0] merged_strb_i,
	input  logic [merge_pkg::data_w-1:0] merged_data_i,
	output merge_pkg::lut_entry_t [merge_pkg::num_outstanding-1:0] lut_o,
	input  logic                         clr0_i,
	input  logic                         clr1_i,
	input  merge_pkg::req_id_t           clr_id_i
);
	import merge_pkg::*;

	lut_entry_t [num_outstanding-1:0] lut_q;

	// Merged request accepted by memory port 0
	logic merge_fire;
	req_id_t set_id;

	always_comb begin
		// Straight pass-through by default
		mem0_o.req = core0_i.req;
		mem0_o.q_valid = core0_i.q_valid;
		mem1_o.req = core1_i.req;
		mem1_o.q_valid = core1_i.q_valid;
		core0_i.q_ready = mem0_o.q_ready;
		core1_i.q_ready = mem1_o.q_ready;

		if (merge_i) begin
			// Port 0 carries the combined write
			mem0_o.req.strb = merged_strb_i;
			mem0_o.req.data = merged_data_i;
			// Port 1 stays idle on the memory side
			mem1_o.q_valid = 1'b0;
			// Port 1 is accepted together with the merged write
			core1_i.q_ready = mem0_o.q_ready;
		end
	end

	assign merge_fire = merge_i && mem0_o.q_valid && mem0_o.q_ready;

	// Indexed by the port 0 id that the memory echoes back
	assign set_id = core0_i.req.user.req_id;

	// Owed bits and port 1 user
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < num_outstanding; i++) begin
				lut_q[i].owed0 <= 1'b0;
				lut_q[i].owed1 <= 1'b0;
			end
		end else begin
			// Result side reports each port's acceptance
			if (clr0_i) begin
				lut_q[clr_id_i].owed0 <= 1'b0;
			end
			if (clr1_i) begin
				lut_q[clr_id_i].owed1 <= 1'b0;
			end
			// Set comes last so it wins over a clear to the same entry
			if (merge_fire) begin
				lut_q[set_id].owed0 <= 1'b1;
				lut_q[set_id].owed1 <= 1'b1;
				// Port 1 user is restored on its copy of the merged response
				lut_q[set_id].user1 <= core1_i.req.user;
			end
		end
	end

	assign lut_o = lut_q;

endmodule

`default_nettype wire

/* source/merge_result.sv */
`timescale 1ns/1ns
`default_nettype none

module merge_result (
	port_if.responder                    core0_o,
	port_if.responder                    core1_o,
	port_if.requester                    mem0_i,
	port_if.requester                    mem1_i,
	input  merge_pkg::lut_entry_t [merge_pkg::num_outstanding-1:0] lut_i,
	output logic                         clr0_o,
	output logic                         clr1_o,
	output merge_pkg::req_id_t           clr_id_o
);
	import merge_pkg::*;

	req_id_t rsp_id;
	lut_entry_t ent;
	logic merged;
	logic take0;
	logic take1;

	// Entry for whatever memory port 0 is returning
	assign rsp_id = mem0_i.rsp.user.req_id;
	assign ent = lut_i[rsp_id];

	// A write response with any owed bit belongs to a merged write
	assign merged = mem0_i.p_valid && mem0_i.rsp.write && (ent.owed0 || ent.owed1);

	// Acceptance by each core port of its copy
	assign take0 = merged && ent.owed0 && core0_o.p_ready;
	assign take1 = merged && ent.owed1 && core1_o.p_ready;

	always_comb begin
		// Own paths by default
		core0_o.rsp = mem0_i.rsp;
		core0_o.p_valid = mem0_i.p_valid;
		mem0_i.p_ready = core0_o.p_ready;
		core1_o.rsp = mem1_i.rsp;
		core1_o.p_valid = mem1_i.p_valid;
		mem1_i.p_ready = core1_o.p_ready;

		if (merged) begin
			// Port 0 sees it only until it has taken it
			core0_o.p_valid = ent.owed0;

			if (ent.owed1) begin
				// Port 1 gets the same response under its own user
				core1_o.rsp = mem0_i.rsp;
				core1_o.rsp.user = ent.user1;
				core1_o.p_valid = 1'b1;
				// Memory port 1 waits until the merged copy is gone
				mem1_i.p_ready = 1'b0;
			end

			// Free the memory only when no owed bit survives this cycle
			mem0_i.p_ready = (ent.owed0 == take0) && (ent.owed1 == take1);
		end
	end

	assign clr0_o = take0;
	assign clr1_o = take1;
	assign clr_id_o = rsp_id;

endmodule

`default_nettype wire

/* source/word_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module word_mem (
	input logic       clk_i,
	input logic       reset_i,
	port_if.responder port0_i,
	port_if.responder port1_i
);
	import merge_pkg::*;

	localparam int unsigned depth = 1 << addr_w;

	mem_word_u mem_q [depth];

	// Both ports as arrays so one loop serves them
	mem_req_t req [2];
	logic [1:0] q_valid;
	logic [1:0] p_ready;
	logic [1:0] rdy;
	logic [1:0] acc;
	logic [1:0] take;

	// One held response per port
	logic [1:0] pend_q;
	mem_rsp_t rsp_q [2];

	always_comb begin
		req[0] = port0_i.req;
		req[1] = port1_i.req;
		q_valid = {port1_i.q_valid, port0_i.q_valid};
		p_ready = {port1_i.p_ready, port0_i.p_ready};
		for (int p = 0; p < 2; p++) begin
			take[p] = pend_q[p] && p_ready[p];
			// Blocked while a response waits untaken
			rdy[p] = !pend_q[p] || take[p];
			acc[p] = q_valid[p] && rdy[p];
		end
	end

	assign port0_i.q_ready = rdy[0];
	assign port1_i.q_ready = rdy[1];
	assign port0_i.p_valid = pend_q[0];
	assign port1_i.p_valid = pend_q[1];
	assign port0_i.rsp = rsp_q[0];
	assign port1_i.rsp = rsp_q[1];

	// Response valid flags
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pend_q <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (acc[p]) begin
					pend_q[p] <= 1'b1;
				end else if (take[p]) begin
					pend_q[p] <= 1'b0;
				end
			end
		end
	end

	// Storage, cleared by reset
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int w = 0; w < depth; w++) begin
				mem_q[w] <= '0;
			end
		end else begin
			// Port 1 is written last, so its bytes win a collision
			for (int p = 0; p < 2; p++) begin
				if (acc[p] && req[p].write) begin
					for (int b = 0; b < strb_w; b++) begin
						if (req[p].strb[b]) begin
							mem_q[req[p].addr].bytes[b] <= req[p].data[b*8 +: 8];
						end
					end
				end
			end
		end
	end

	// Response payload
	// reads see the word before any same-cycle write
	always_ff @(posedge clk_i) begin
		for (int p = 0; p < 2; p++) begin
			if (acc[p]) begin
				rsp_q[p].write <= req[p].write;
				rsp_q[p].user <= req[p].user;
				rsp_q[p].data <= req[p].write ? '0 : mem_q[req[p].addr].word;
			end
		end
	end

endmodule

`default_nettype wire

/* source/merge_top.sv */
`timescale 1ns/1ns
`default_nettype none

module merge_top (
	input  logic                         clk_i,
	input  logic                         reset_i,
	// Core port 0
	input  logic                         q_valid0_i,
	output logic                         q_ready0_o,
	input  logic [merge_pkg::addr_w-1:0] addr0_i,
	input  logic                         write0_i,
	input  logic [merge_pkg::strb_w-1:0] strb0_i,
	input  logic [merge_pkg::data_w-1:0] data0_i,
	input  merge_pkg::req_id_t           id0_i,
	input  logic [merge_pkg::tag_w-1:0]  tag0_i,
	output logic                         p_valid0_o,
	input  logic                         p_ready0_i,
	output logic                         rsp_write0_o,
	output logic [merge_pkg::data_w-1:0] rsp_data0_o,
	output merge_pkg::req_id_t           rsp_id0_o,
	output logic [merge_pkg::tag_w-1:0]  rsp_tag0_o,
	// Core port 1
	input  logic                         q_valid1_i,
	output logic                         q_ready1_o,
	input  logic [merge_pkg::addr_w-1:0] addr1_i,
	input  logic                         write1_i,
	input  logic [merge_pkg::strb_w-1:0] strb1_i,
	input  logic [merge_pkg::data_w-1:0] data1_i,
	input  merge_pkg::req_id_t           id1_i,
	input  logic [merge_pkg::tag_w-1:0]  tag1_i,
	output logic                         p_valid1_o,
	input  logic                         p_ready1_i,
	output logic                         rsp_write1_o,
	output logic [merge_pkg::data_w-1:0] rsp_data1_o,
	output merge_pkg::req_id_t           rsp_id1_o,
	output logic [merge_pkg::tag_w-1:0]  rsp_tag1_o
);
	import merge_pkg::*;

	// Core side and memory side channels
	port_if core0_if (.clk_i(clk_i));
	port_if core1_if (.clk_i(clk_i));
	port_if mem0_if (.clk_i(clk_i));
	port_if mem1_if (.clk_i(clk_i));

	logic merge;
	logic [strb_w-1:0] merged_strb;
	logic [data_w-1:0] merged_data;
	lut_entry_t [num_outstanding-1:0] lut;
	logic clr0;
	logic clr1;
	req_id_t clr_id;

	// Pack the flat core ports into the channels
	assign core0_if.req = '{addr: addr0_i, write: write0_i, strb: strb0_i, data: data0_i,
		user: '{req_id: id0_i, tag: tag0_i}};
	assign core0_if.q_valid = q_valid0_i;
	assign core0_if.p_ready = p_ready0_i;
	assign core1_if.req = '{addr: addr1_i, write: write1_i, strb: strb1_i, data: data1_i,
		user: '{req_id: id1_i, tag: tag1_i}};
	assign core1_if.q_valid = q_valid1_i;
	assign core1_if.p_ready = p_ready1_i;

	// Unpack responses
	assign q_ready0_o = core0_if.q_ready;
	assign p_valid0_o = core0_if.p_valid;
	assign rsp_write0_o = core0_if.rsp.write;
	assign rsp_data0_o = core0_if.rsp.data;
	assign rsp_id0_o = core0_if.rsp.user.req_id;
	assign rsp_tag0_o = core0_if.rsp.user.tag;
	assign q_ready1_o = core1_if.q_ready;
	assign p_valid1_o = core1_if.p_valid;
	assign rsp_write1_o = core1_if.rsp.write;
	assign rsp_data1_o = core1_if.rsp.data;
	assign rsp_id1_o = core1_if.rsp.user.req_id;
	assign rsp_tag1_o = core1_if.rsp.user.tag;

	merge_decode u_decode (
		.port0_i       (core0_if),
		.port1_i       (core1_if),
		.merge_o       (merge),
		.merged_strb_o (merged_strb),
		.merged_data_o (merged_data)
	);

	merge_execute u_execute (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.core0_i       (core0_if),
		.core1_i       (core1_if),
		.mem0_o        (mem0_if),
		.mem1_o        (mem1_if),
		.merge_i       (merge),
		.merged_strb_i (merged_strb),
		.merged_data_i (merged_data),
		.lut_o         (lut),
		.clr0_i        (clr0),
		.clr1_i        (clr1),
		.clr_id_i      (clr_id)
	);

	merge_result u_result (
		.core0_o  (core0_if),
		.core1_o  (core1_if),
		.mem0_i   (mem0_if),
		.mem1_i   (mem1_if),
		.lut_i    (lut),
		.clr0_o   (clr0),
		.clr1_o   (clr1),
		.clr_id_o (clr_id)
	);

	word_mem u_mem (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.port0_i (mem0_if),
		.port1_i (mem1_if)
	);

endmodule

`default_nettype wire

/* tb/tb_merge_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_merge_top;
	import merge_pkg::*;

	localparam int num_tests = 6;

	typedef struct packed {
		logic        write;
		logic [31:0] data;
		logic [3:0]  id;
		logic [3:0]  tag;
	} exp_t;

	// Names match the DUT ports so the instance connects by name
	logic        clk_i = 1'b0;
	logic        reset_i;
	logic        q_valid0_i;
	logic        q_valid1_i;
	logic        write0_i;
	logic        write1_i;
	logic        p_ready0_i;
	logic        p_ready1_i;
	logic [7:0]  addr0_i;
	logic [7:0]  addr1_i;
	logic [3:0]  strb0_i;
	logic [3:0]  strb1_i;
	logic [3:0]  id0_i;
	logic [3:0]  id1_i;
	logic [3:0]  tag0_i;
	logic [3:0]  tag1_i;
	logic [31:0] data0_i;
	logic [31:0] data1_i;
	logic        q_ready0_o;
	logic        q_ready1_o;
	logic        p_valid0_o;
	logic        p_valid1_o;
	logic        rsp_write0_o;
	logic        rsp_write1_o;
	logic [31:0] rsp_data0_o;
	logic [31:0] rsp_data1_o;
	logic [3:0]  rsp_id0_o;
	logic [3:0]  rsp_id1_o;
	logic [3:0]  rsp_tag0_o;
	logic [3:0]  rsp_tag1_o;

	// Responses still owed to each core port in arrival order
	exp_t exp0_q[$];
	exp_t exp1_q[$];
	// Byte-strobed image of the memory
	logic [31:0] model [256];
	int errors = 0;
	int checks = 0;
	int err_mark = 0;
	integer seed = 32'h925d7783;

	merge_top dut0 (.*);

	always #4 clk_i = ~clk_i;

	// Watchdog allows 200 cycles per test
	initial begin
		#(num_tests * 200 * 8);
		$display("Timeout: the test sequence stopped making progress");
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] rnd();
		rnd = $random(seed);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic report_test(input string name);
		$display("%s finished, %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// Loads one port's request and raises its valid
	task automatic set_req(input int port, input logic wr, input logic [7:0] a,
		input logic [3:0] s, input logic [31:0] d, input logic [3:0] id, input logic [3:0] tag);
		if (port == 0) begin
			{write0_i, addr0_i, strb0_i, data0_i} = {wr, a, s, d};
			{id0_i, tag0_i} = {id, tag};
			q_valid0_i = 1'b1;
		end else begin
			{write1_i, addr1_i, strb1_i, data1_i} = {wr, a, s, d};
			{id1_i, tag1_i} = {id, tag};
			q_valid1_i = 1'b1;
		end
	endtask

	task automatic write_model(input logic [7:0] a, input logic [3:0] s, input logic [31:0] d);
		for (int b = 0; b < 4; b++) begin
			if (s[b]) model[a][b*8 +: 8] = d[b*8 +: 8];
		end
	endtask

	// Holds each request until it transfers and predicts its response
	task automatic wait_accept();
		logic acc0;
		logic acc1;
		exp_t e;
		while (q_valid0_i || q_valid1_i) begin
			@(negedge clk_i);
			acc0 = q_valid0_i && q_ready0_o;
			acc1 = q_valid1_i && q_ready1_o;
			// Reads return the word as it was before this cycle's writes
			if (acc0) begin
				e = '{write0_i, (write0_i ? 32'h0 : model[addr0_i]), id0_i, tag0_i};
				exp0_q.push_back(e);
			end
			if (acc1) begin
				e = '{write1_i, (write1_i ? 32'h0 : model[addr1_i]), id1_i, tag1_i};
				exp1_q.push_back(e);
			end
			// Port 1 lanes land last for a merge and for a collision alike
			if (acc0 && write0_i) write_model(addr0_i, strb0_i, data0_i);
			if (acc1 && write1_i) write_model(addr1_i, strb1_i, data1_i);
			@(posedge clk_i);
			#1;
			if (acc0) q_valid0_i = 1'b0;
			if (acc1) q_valid1_i = 1'b0;
		end
	endtask

	task automatic drain();
		while (exp0_q.size() != 0 || exp1_q.size() != 0) @(negedge clk_i);
		// A few quiet cycles so a duplicate response shows up
		repeat (3) @(negedge clk_i);
		@(posedge clk_i);
		#1;
	endtask

	task automatic run();
		wait_accept();
		drain();
	endtask

	task automatic collect_response(input int port, input logic w, input logic [31:0] d,
		input logic [3:0] id, input logic [3:0] tag);
		exp_t e;
		if ((port == 0 && exp0_q.size() == 0) || (port == 1 && exp1_q.size() == 0)) begin
			errors++;
			$display("Port %0d returned a response nobody was waiting for at %0t", port, $time);
		end else begin
			if (port == 0) e = exp0_q.pop_front();
			else e = exp1_q.pop_front();
			check_value($sformatf("rsp_write%0d_o", port), {31'h0, e.write}, {31'h0, w});
			check_value($sformatf("rsp_data%0d_o", port), e.data, d);
			check_value($sformatf("rsp_id%0d_o", port), {28'h0, e.id}, {28'h0, id});
			check_value($sformatf("rsp_tag%0d_o", port), {28'h0, e.tag}, {28'h0, tag});
		end
	endtask

	// At most one transfer per port per cycle
	always @(negedge clk_i) begin
		if (!reset_i && p_valid0_o && p_ready0_i) begin
			collect_response(0, rsp_write0_o, rsp_data0_o, rsp_id0_o, rsp_tag0_o);
		end
		if (!reset_i && p_valid1_o && p_ready1_i) begin
			collect_response(1, rsp_write1_o, rsp_data1_o, rsp_id1_o, rsp_tag1_o);
		end
	end

	task automatic pass_through();
		set_req(0, 1'b1, 8'h10, 4'hf, rnd(), 4'h1, 4'h2);
		run();
		set_req(1, 1'b1, 8'h20, 4'h5, rnd(), 4'h3, 4'h4);
		run();
		// Both ports on different words
		set_req(0, 1'b1, 8'h20, 4'ha, rnd(), 4'h5, 4'h6);
		set_req(1, 1'b1, 8'h10, 4'h6, rnd(), 4'h7, 4'h8);
		run();
		set_req(0, 1'b0, 8'h10, 4'h0, 32'h0, 4'h1, 4'h9);
		set_req(1, 1'b0, 8'h20, 4'h0, 32'h0, 4'h2, 4'ha);
		run();
	endtask

	task automatic merge_data();
		logic [7:0] a;
		for (int i = 0; i < 6; i++) begin
			a = 8'(rnd());
			// Known old word first
			set_req(1, 1'b1, a, 4'hf, rnd(), 4'h0, 4'h0);
			run();
			set_req(0, 1'b1, a, 4'(rnd()), rnd(), 4'(i), 4'h1);
			set_req(1, 1'b1, a, 4'(rnd()), rnd(), 4'(i + 8), 4'h2);
			run();
			set_req(0, 1'b0, a, 4'h0, 32'h0, 4'(i), 4'h3);
			run();
		end
	endtask

	task automatic fan_out();
		for (int i = 0; i < 3; i++) begin
			set_req(0, 1'b1, 8'h30, 4'hf, rnd(), 4'(i), 4'(i + 1));
			set_req(1, 1'b1, 8'h30, 4'hf, rnd(), 4'(15 - i), 4'(12 - i));
			run();
		end
	endtask

	task automatic independent_accept();
		for (int held = 1; held >= 0; held--) begin
			if (held == 1) p_ready1_i = 1'b0;
			else p_ready0_i = 1'b0;
			set_req(0, 1'b1, 8'h40, 4'hf, rnd(), 4'h5, 4'ha);
			set_req(1, 1'b1, 8'h40, 4'(rnd()), rnd(), 4'h9, 4'h3);
			wait_accept();
			// The free port gets its copy while the other one stalls
			if (held == 1) while (exp0_q.size() != 0) @(negedge clk_i);
			else while (exp1_q.size() != 0) @(negedge clk_i);
			// The held port keeps offering its copy
			repeat (4) begin
				@(negedge clk_i);
				if (held == 1) begin
					check_value("p_valid1_o", 32'h1, {31'h0, p_valid1_o});
				end else begin
					check_value("p_valid0_o", 32'h1, {31'h0, p_valid0_o});
				end
			end
			@(posedge clk_i);
			#1;
			{p_ready0_i, p_ready1_i} = 2'b11;
			drain();
		end
		// Same ids again
		set_req(0, 1'b0, 8'h40, 4'h0, 32'h0, 4'h5, 4'hb);
		set_req(1, 1'b0, 8'h40, 4'h0, 32'h0, 4'h9, 4'hc);
		run();
	endtask

	task automatic back_pressure();
		{p_ready0_i, p_ready1_i} = 2'b00;
		set_req(0, 1'b1, 8'h60, 4'hf, rnd(), 4'h1, 4'h1);
		set_req(1, 1'b1, 8'h61, 4'hf, rnd(), 4'h2, 4'h2);
		wait_accept();
		set_req(0, 1'b0, 8'h61, 4'h0, 32'h0, 4'h3, 4'h3);
		set_req(1, 1'b0, 8'h60, 4'h0, 32'h0, 4'h4, 4'h4);
		// Both responses parked so no new request may enter
		repeat (5) begin
			@(negedge clk_i);
			check_value("q_ready0_o", 32'h0, {31'h0, q_ready0_o});
			check_value("q_ready1_o", 32'h0, {31'h0, q_ready1_o});
		end
		@(posedge clk_i);
		#1;
		{p_ready0_i, p_ready1_i} = 2'b11;
		run();
	endtask

	task automatic non_merge();
		// Two reads with equal addresses on an untouched word
		set_req(0, 1'b0, 8'h80, 4'h0, 32'h0, 4'h6, 4'h1);
		set_req(1, 1'b0, 8'h80, 4'h0, 32'h0, 4'h7, 4'h2);
		run();
		// Read plus write to one word in both orders
		set_req(0, 1'b0, 8'h10, 4'h0, 32'h0, 4'h8, 4'h3);
		set_req(1, 1'b1, 8'h10, 4'hf, rnd(), 4'h9, 4'h4);
		run();
		set_req(0, 1'b1, 8'h10, 4'h3, rnd(), 4'ha, 4'h5);
		set_req(1, 1'b0, 8'h10, 4'h0, 32'h0, 4'hb, 4'h6);
		run();
		set_req(0, 1'b0, 8'h10, 4'h0, 32'h0, 4'hc, 4'h7);
		run();
	endtask

	initial begin
		for (int w = 0; w < 256; w++) model[w] = 32'h0;
		reset_i = 1'b1;
		{q_valid0_i, q_valid1_i, write0_i, write1_i} = 4'h0;
		{addr0_i, addr1_i, strb0_i, strb1_i} = '0;
		{data0_i, data1_i, id0_i, id1_i, tag0_i, tag1_i} = '0;
		{p_ready0_i, p_ready1_i} = 2'b11;
		repeat (4) @(posedge clk_i);
		#1;
		reset_i = 1'b0;
		pass_through();
		report_test("pass_through");
		merge_data();
		report_test("merge_data");
		fan_out();
		report_test("fan_out");
		independent_accept();
		report_test("independent");
		back_pressure();
		report_test("back_pressure");
		non_merge();
		report_test("non_merge");
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/merge_pkg.sv
source/port_if.sv
source/merge_decode.sv
source/merge_execute.sv
source/merge_result.sv
source/word_mem.sv
source/merge_top.sv
tb/tb_merge_top.sv

/* Makefile */
TOP := tb_merge_top

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
